/* source/vdecode_pkg.sv */
// vector decode package with configuration types, offset source encodings and sizing constants
package vdecode_pkg;

  // sizing
  localparam int VLEN          = 128;
  localparam int LANES         = 2;
  localparam int ELEMS_PER_REG = VLEN / 32;
  localparam int OFFSET_W      = 8;

  typedef logic [OFFSET_W-1:0] offset_t;
  typedef logic [31:0]         vl_t;
  typedef logic [4:0]          reg_idx_t;
  typedef logic [31:0]         word_t;
  typedef logic [2:0]          nf_t;

  // element widths, encoded as log2 of the byte count
  typedef enum logic [1:0] {
    SEW8  = 2'd0,
    SEW16 = 2'd1,
    SEW32 = 2'd2
  } sew_t;

  typedef enum logic [1:0] {
    WIDTH8  = 2'd0,
    WIDTH16 = 2'd1,
    WIDTH32 = 2'd2
  } width_t;

  // register grouping, vtype vlmul field encoding
  typedef enum logic [2:0] {
    LMUL1      = 3'b000,
    LMUL2      = 3'b001,
    LMUL4      = 3'b010,
    LMUL8      = 3'b011,
    LMULFOURTH = 3'b110,
    LMULHALF   = 3'b111
  } vlmul_t;

  typedef enum logic [2:0] {
    VS2_SRC_NORMAL        = 3'd0,
    VS2_SRC_IDX_PLUS_RS1  = 3'd1,
    VS2_SRC_IDX_PLUS_UIMM = 3'd2,
    VS2_SRC_IDX_PLUS_1    = 3'd3,
    VS2_SRC_IDX_MINUS_1   = 3'd4,
    VS2_SRC_RS1           = 3'd5,
    VS2_SRC_UIMM          = 3'd6,
    VS2_SRC_ZERO          = 3'd7
  } vs2_src_t;

  typedef enum logic [2:0] {
    VD_SRC_NORMAL        = 3'd0,
    VD_SRC_ZERO          = 3'd1,
    VD_SRC_IDX_PLUS_RS1  = 3'd2,
    VD_SRC_IDX_PLUS_UIMM = 3'd3,
    VD_SRC_IDX_PLUS_1    = 3'd4
  } vd_src_t;

  typedef enum logic [2:0] {
    RED_NONE = 3'd0,
    RED_SUM  = 3'd1,
    RED_AND  = 3'd2,
    RED_MIN  = 3'd3,
    RED_MINU = 3'd4,
    RED_MAX  = 3'd5,
    RED_MAXU = 3'd6
  } red_op_t;

endpackage

/* source/element_counter.sv */
// element counter that walks element offsets two lanes per cycle from vstart to the element count
`timescale 1ns/1ps

module element_counter import vdecode_pkg::*; (
  input  logic    CLK,
  input  logic    nRST,
  input  logic    start,
  input  logic    restart,
  input  logic    stall,
  input  logic    flush,
  input  vl_t     vstart,
  input  vl_t     elem_vl,
  output offset_t offset,
  output logic    active,
  output logic    done
);

  vl_t     pair_end;
  offset_t start_offset;

  // first element after the current lane pair
  assign pair_end     = vl_t'(offset) + vl_t'(LANES);
  assign start_offset = vstart[OFFSET_W-1:0];

  // final pair of this field
  assign done = active && (pair_end >= elem_vl);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      offset <= '0;
      active <= 1'b0;
    end else if (flush) begin
      offset <= '0;
      active <= 1'b0;
    end else if (start) begin
      offset <= start_offset;
      active <= 1'b1;
    end else if (active && !stall) begin
      if (done) begin
        // next segment field walks again from vstart
        if (restart) begin
          offset <= start_offset;
        end else begin
          active <= 1'b0;
        end
      end else begin
        offset <= offset + offset_t'(LANES);
      end
    end
  end

endmodule

/* source/emul_calc.sv */
// EMUL and element count derivation for the current vector instruction
`timescale 1ns/1ps

module emul_calc import vdecode_pkg::*; (
  input  sew_t   sew,
  input  vlmul_t lmul,
  input  width_t eew,
  input  logic   is_load,
  input  logic   is_store,
  input  logic   full_reg,
  input  nf_t    nf,
  input  vl_t    vl,
  output vlmul_t emul,
  output vl_t    elem_vl
);

  logic              is_mem;
  logic signed [3:0] emul_log;
  vlmul_t            mem_emul;

  // log2 of the grouping, fractional groupings negative
  function automatic logic signed [3:0] lmul_log(input vlmul_t m);
    case (m)
      LMULFOURTH: lmul_log = -4'sd2;
      LMULHALF:   lmul_log = -4'sd1;
      LMUL2:      lmul_log = 4'sd1;
      LMUL4:      lmul_log = 4'sd2;
      LMUL8:      lmul_log = 4'sd3;
      default:    lmul_log = 4'sd0;
    endcase
  endfunction

  assign is_mem = is_load | is_store;

  // EMUL = EEW / SEW * LMUL, done in the log domain
  assign emul_log = lmul_log(lmul) + signed'({2'b00, eew}) - signed'({2'b00, sew});

  always_comb begin
    if (emul_log <= -4'sd2) begin
      mem_emul = LMULFOURTH;
    end else if (emul_log >= 4'sd3) begin
      mem_emul = LMUL8;
    end else begin
      case (emul_log)
        -4'sd1:  mem_emul = LMULHALF;
        4'sd1:   mem_emul = LMUL2;
        4'sd2:   mem_emul = LMUL4;
        default: mem_emul = LMUL1;
      endcase
    end
  end

  assign emul = is_mem ? mem_emul : lmul;

  // whole-register moves cover every element of nf+1 registers
  always_comb begin
    if (is_mem && full_reg) begin
      elem_vl = vl_t'(ELEMS_PER_REG) * (vl_t'(nf) + 32'd1);
    end else begin
      elem_vl = vl;
    end
  end

endmodule

/* source/segment_sequencer.sv */
// segment field sequencer that steps the destination register by EMUL for each field
`timescale 1ns/1ps

module segment_sequencer import vdecode_pkg::*; (
  input  logic     CLK,
  input  logic     nRST,
  input  logic     start,
  input  logic     done,
  input  logic     stall,
  input  logic     flush,
  input  logic     is_load,
  input  logic     is_store,
  input  logic     full_reg,
  input  nf_t      nf,
  input  vlmul_t   emul,
  input  reg_idx_t vd,
  output logic     restart,
  output logic     last_field,
  output reg_idx_t cur_vd
);

  nf_t        field_idx;
  logic       segment;
  logic [1:0] reg_shift;
  reg_idx_t   vd_step;

  // strided/unit segment access, whole-register ops are a single field
  assign segment    = (is_load | is_store) & ~full_reg & (nf != '0);
  assign last_field = ~segment | (field_idx == nf);
  assign restart    = done & ~last_field;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      field_idx <= '0;
    end else if (flush || start) begin
      field_idx <= '0;
    end else if (done && !stall) begin
      if (last_field) begin
        field_idx <= '0;
      end else begin
        field_idx <= field_idx + nf_t'(1);
      end
    end
  end

  // registers per field, fractional groupings still take one
  always_comb begin
    case (emul)
      LMUL2:   reg_shift = 2'd1;
      LMUL4:   reg_shift = 2'd2;
      LMUL8:   reg_shift = 2'd3;
      default: reg_shift = 2'd0;
    endcase
  end

  // wraps modulo 32 like the register index
  assign vd_step = reg_idx_t'(field_idx) << reg_shift;
  assign cur_vd  = vd + vd_step;

endmodule

/* source/offset_select.sv */
// offset selection for destination and source-2 lanes with masked write enables
`timescale 1ns/1ps

module offset_select import vdecode_pkg::*; (
  input  offset_t    offset,
  input  vs2_src_t   vs2_src,
  input  vd_src_t    vd_src,
  input  word_t      xs1,
  input  logic [4:0] imm5,
  input  logic       vm,
  input  logic [1:0] mask_bits,
  input  vl_t        vstart,
  input  vl_t        vl,
  input  logic       is_store,
  output offset_t    woffset0,
  output offset_t    woffset1,
  output offset_t    vs2_offset0,
  output offset_t    vs2_offset1,
  output logic       wen0,
  output logic       wen1
);

  offset_t rs1_off;
  offset_t uimm_off;
  logic    vs2_fixed;
  logic    window_ok;

  assign rs1_off  = xs1[OFFSET_W-1:0];
  assign uimm_off = offset_t'(imm5);

  always_comb begin
    vs2_fixed = 1'b0;
    case (vs2_src)
      VS2_SRC_IDX_PLUS_RS1:  vs2_offset0 = offset + rs1_off;
      VS2_SRC_IDX_PLUS_UIMM: vs2_offset0 = offset + uimm_off;
      VS2_SRC_IDX_PLUS_1:    vs2_offset0 = offset + offset_t'(1);
      VS2_SRC_IDX_MINUS_1:   vs2_offset0 = offset - offset_t'(1);
      VS2_SRC_RS1: begin
        vs2_offset0 = rs1_off;
        vs2_fixed   = 1'b1;
      end
      VS2_SRC_UIMM: begin
        vs2_offset0 = uimm_off;
        vs2_fixed   = 1'b1;
      end
      VS2_SRC_ZERO: begin
        vs2_offset0 = '0;
        vs2_fixed   = 1'b1;
      end
      default:               vs2_offset0 = offset;
    endcase
  end

  // scalar and immediate sources feed both lanes the same element
  assign vs2_offset1 = vs2_fixed ? vs2_offset0 : vs2_offset0 + offset_t'(1);

  always_comb begin
    case (vd_src)
      VD_SRC_ZERO:          woffset0 = '0;
      VD_SRC_IDX_PLUS_RS1:  woffset0 = offset + rs1_off;
      VD_SRC_IDX_PLUS_UIMM: woffset0 = offset + uimm_off;
      VD_SRC_IDX_PLUS_1:    woffset0 = offset + offset_t'(1);
      default:              woffset0 = offset;
    endcase
  end

  assign woffset1 = (vd_src == VD_SRC_ZERO) ? woffset0 : woffset0 + offset_t'(1);

  // nothing is written past the vstart/vl window or by a store
  assign window_ok = (vstart < vl) & ~is_store;
  assign wen0      = window_ok & (vm | mask_bits[0]);
  assign wen1      = window_ok & (vm | mask_bits[1]);

endmodule

/* source/decode_execute_reg.sv */
// decode/execute pipeline register with stall hold, flush clear and reduction identity
`timescale 1ns/1ps

module decode_execute_reg import vdecode_pkg::*; (
  input  logic     CLK,
  input  logic     nRST,
  input  logic     stall,
  input  logic     flush,
  input  logic     active,
  input  logic     done,
  input  logic     last_field,
  input  reg_idx_t cur_vd,
  input  offset_t  woffset0,
  input  offset_t  woffset1,
  input  offset_t  vs2_offset0,
  input  offset_t  vs2_offset1,
  input  logic     wen0,
  input  logic     wen1,
  input  red_op_t  red_op,
  input  vl_t      elem_vl,
  output logic     de_valid,
  output reg_idx_t de_vd,
  output offset_t  de_woffset0,
  output offset_t  de_woffset1,
  output offset_t  de_vs2_offset0,
  output offset_t  de_vs2_offset1,
  output logic     de_wen0,
  output logic     de_wen1,
  output word_t    de_red_init,
  output vl_t      de_vl,
  output logic     de_done
);

  logic  is_red;
  word_t red_init;

  assign is_red = (red_op != RED_NONE);

  // starting accumulator for each reduction kind
  always_comb begin
    case (red_op)
      RED_AND, RED_MINU: red_init = 32'hffff_ffff;
      RED_MIN:           red_init = 32'h7fff_ffff;
      RED_MAX:           red_init = 32'h8000_0000;
      default:           red_init = '0;
    endcase
  end

  // control half of the record
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      de_valid <= 1'b0;
      de_wen0  <= 1'b0;
      de_wen1  <= 1'b0;
      de_done  <= 1'b0;
    end else if (flush) begin
      de_valid <= 1'b0;
      de_wen0  <= 1'b0;
      de_wen1  <= 1'b0;
      de_done  <= 1'b0;
    end else if (!stall) begin
      de_valid <= active;
      de_wen0  <= active & wen0;
      // reductions accumulate through lane 0 only
      de_wen1  <= active & wen1 & ~is_red;
      de_done  <= done & last_field;
    end
  end

  // payload half, only meaningful with de_valid
  always_ff @(posedge CLK) begin
    if (!stall) begin
      de_vd          <= cur_vd;
      de_woffset0    <= woffset0;
      de_woffset1    <= woffset1;
      de_vs2_offset0 <= vs2_offset0;
      de_vs2_offset1 <= vs2_offset1;
      de_red_init    <= red_init;
      de_vl          <= elem_vl;
    end
  end

endmodule

/* source/vdecode_stage.sv */
// vector decode stage top level with element sequencing and the busy latch
`timescale 1ns/1ps

module vdecode_stage import vdecode_pkg::*; (
  input  logic       CLK,
  input  logic       nRST,
  input  logic       v_start,
  input  logic       stall,
  input  logic       flush,
  input  sew_t       sew,
  input  vlmul_t     lmul,
  input  width_t     eew,
  input  vl_t        vl,
  input  vl_t        vstart,
  input  logic       is_load,
  input  logic       is_store,
  input  logic       full_reg,
  input  nf_t        nf,
  input  reg_idx_t   vd,
  input  vs2_src_t   vs2_src,
  input  vd_src_t    vd_src,
  input  word_t      xs1,
  input  logic [4:0] imm5,
  input  logic       vm,
  input  logic [1:0] mask_bits,
  input  red_op_t    red_op,
  output logic       de_valid,
  output reg_idx_t   de_vd,
  output offset_t    de_woffset0,
  output offset_t    de_woffset1,
  output offset_t    de_vs2_offset0,
  output offset_t    de_vs2_offset1,
  output logic       de_wen0,
  output logic       de_wen1,
  output word_t      de_red_init,
  output vl_t        de_vl,
  output logic       de_done,
  output logic       busy
);

  vlmul_t   emul;
  vl_t      elem_vl;
  offset_t  offset;
  logic     active;
  logic     done;
  logic     restart;
  logic     last_field;
  reg_idx_t cur_vd;
  offset_t  woffset0;
  offset_t  woffset1;
  offset_t  vs2_offset0;
  offset_t  vs2_offset1;
  logic     wen0;
  logic     wen1;

  emul_calc u_emul_calc (
    .sew(sew), .lmul(lmul), .eew(eew), .is_load(is_load), .is_store(is_store),
    .full_reg(full_reg), .nf(nf), .vl(vl), .emul(emul), .elem_vl(elem_vl)
  );

  element_counter u_element_counter (
    .CLK(CLK), .nRST(nRST), .start(v_start), .restart(restart), .stall(stall),
    .flush(flush), .vstart(vstart), .elem_vl(elem_vl), .offset(offset),
    .active(active), .done(done)
  );

  segment_sequencer u_segment_sequencer (
    .CLK(CLK), .nRST(nRST), .start(v_start), .done(done), .stall(stall),
    .flush(flush), .is_load(is_load), .is_store(is_store), .full_reg(full_reg),
    .nf(nf), .emul(emul), .vd(vd), .restart(restart), .last_field(last_field),
    .cur_vd(cur_vd)
  );

  offset_select u_offset_select (
    .offset(offset), .vs2_src(vs2_src), .vd_src(vd_src), .xs1(xs1), .imm5(imm5),
    .vm(vm), .mask_bits(mask_bits), .vstart(vstart), .vl(vl), .is_store(is_store),
    .woffset0(woffset0), .woffset1(woffset1), .vs2_offset0(vs2_offset0),
    .vs2_offset1(vs2_offset1), .wen0(wen0), .wen1(wen1)
  );

  decode_execute_reg u_decode_execute_reg (
    .CLK(CLK), .nRST(nRST), .stall(stall), .flush(flush), .active(active),
    .done(done), .last_field(last_field), .cur_vd(cur_vd), .woffset0(woffset0),
    .woffset1(woffset1), .vs2_offset0(vs2_offset0), .vs2_offset1(vs2_offset1),
    .wen0(wen0), .wen1(wen1), .red_op(red_op), .elem_vl(elem_vl),
    .de_valid(de_valid), .de_vd(de_vd), .de_woffset0(de_woffset0),
    .de_woffset1(de_woffset1), .de_vs2_offset0(de_vs2_offset0),
    .de_vs2_offset1(de_vs2_offset1), .de_wen0(de_wen0), .de_wen1(de_wen1),
    .de_red_init(de_red_init), .de_vl(de_vl), .de_done(de_done)
  );

  // busy from start until the last record leaves, a new start wins over done
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      busy <= 1'b0;
    end else if (flush) begin
      busy <= 1'b0;
    end else if (v_start) begin
      busy <= 1'b1;
    end else if (de_done) begin
      busy <= 1'b0;
    end
  end

endmodule

/* tb/tb_vdecode_sva.sv */
// decode stage assertions on reduction lane gating, reset state and busy tracking
`timescale 1ns/1ps

module tb_vdecode_sva import vdecode_pkg::*; (
  input logic  CLK,
  input logic  nRST,
  input logic  de_valid,
  input logic  de_wen1,
  input logic  de_done,
  input logic  busy,
  input word_t de_red_init
);

  // a nonzero identity marks a reduction, which writes through lane 0 only
  a_red_lane1: assert property (@(posedge CLK) disable iff (!nRST)
    (de_valid && de_red_init != '0) |-> !de_wen1)
    else $error("lane 1 write enable set on a reduction record");

  a_reset_clear: assert property (@(posedge CLK) !nRST |-> (!de_valid && !de_done && !busy))
    else $error("record control or busy set during reset");

  // busy covers every record of an instruction short of its last
  a_busy_hold: assert property (@(posedge CLK) disable iff (!nRST)
    (de_valid && !de_done) |-> busy)
    else $error("busy low while records of an instruction were still leaving");

endmodule

bind vdecode_stage tb_vdecode_sva u_tb_vdecode_sva (
  .CLK(CLK), .nRST(nRST), .de_valid(de_valid), .de_wen1(de_wen1),
  .de_done(de_done), .busy(busy), .de_red_init(de_red_init)
);

/* tb/tb_vdecode.sv */
// vector decode stage testbench with random instructions and a record-level reference model
`timescale 1ns/1ps

module tb_vdecode import vdecode_pkg::*; ();

  logic       CLK, nRST, v_start, stall, flush;
  sew_t       sew;
  vlmul_t     lmul;
  width_t     eew;
  vl_t        vl, vstart;
  logic       is_load, is_store, full_reg;
  nf_t        nf;
  reg_idx_t   vd;
  vs2_src_t   vs2_src;
  vd_src_t    vd_src;
  word_t      xs1;
  logic [4:0] imm5;
  logic       vm;
  logic [1:0] mask_bits;
  red_op_t    red_op;
  logic       de_valid, de_wen0, de_wen1, de_done, busy;
  reg_idx_t   de_vd;
  offset_t    de_woffset0, de_woffset1, de_vs2_offset0, de_vs2_offset1;
  word_t      de_red_init;
  vl_t        de_vl;

  // one expected decode/execute record
  typedef struct packed {
    reg_idx_t vd;
    offset_t  wo0, wo1, vo0, vo1;
    logic     wen0, wen1;
    word_t    red;
    vl_t      vl;
    logic     done;
  } rec_t;

  rec_t   exp_q[$];
  int     n_tests, n_checks, n_errors, test_err0;
  vlmul_t lmul_tbl [6] = '{LMULFOURTH, LMULHALF, LMUL1, LMUL2, LMUL4, LMUL8};

  vdecode_stage u_vdecode_stage (.*);

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  task automatic check_offset(input string what, input offset_t got, input offset_t want);
    n_checks++;
    if (got !== want) begin
      n_errors++;
      $display("MISMATCH at %0t: %s got %0h expected %0h", $time, what, got, want);
    end
  endtask

  task automatic check_reg(input string what, input reg_idx_t got, input reg_idx_t want);
    n_checks++;
    if (got !== want) begin
      n_errors++;
      $display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, want);
    end
  endtask

  task automatic check_word(input string what, input word_t got, input word_t want);
    n_checks++;
    if (got !== want) begin
      n_errors++;
      $display("MISMATCH at %0t: %s got %0h expected %0h", $time, what, got, want);
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic want);
    n_checks++;
    if (got !== want) begin
      n_errors++;
      $display("MISMATCH at %0t: %s got %b expected %b", $time, what, got, want);
    end
  endtask

  // registers per field with EMUL kept in eighths of a register
  function automatic int regs_per_field();
    int lm8;
    int e8;
    case (lmul)
      LMULFOURTH: lm8 = 2;
      LMULHALF:   lm8 = 4;
      LMUL2:      lm8 = 16;
      LMUL4:      lm8 = 32;
      LMUL8:      lm8 = 64;
      default:    lm8 = 8;
    endcase
    e8 = ((1 << int'(eew)) * lm8) / (1 << int'(sew));
    e8 = (e8 < 2) ? 2 : ((e8 > 64) ? 64 : e8);
    return (e8 < 8) ? 1 : e8 / 8;
  endfunction

  function automatic offset_t vs2_expect(input offset_t base, input int lane);
    case (vs2_src)
      VS2_SRC_RS1:           return xs1[OFFSET_W-1:0];
      VS2_SRC_UIMM:          return offset_t'(imm5);
      VS2_SRC_ZERO:          return '0;
      VS2_SRC_IDX_PLUS_RS1:  return base + xs1[OFFSET_W-1:0] + offset_t'(lane);
      VS2_SRC_IDX_PLUS_UIMM: return base + offset_t'(imm5) + offset_t'(lane);
      VS2_SRC_IDX_PLUS_1:    return base + offset_t'(lane + 1);
      VS2_SRC_IDX_MINUS_1:   return base + offset_t'(lane) - offset_t'(1);
      default:               return base + offset_t'(lane);
    endcase
  endfunction

  function automatic offset_t vd_expect(input offset_t base, input int lane);
    case (vd_src)
      VD_SRC_ZERO:          return '0;
      VD_SRC_IDX_PLUS_RS1:  return base + xs1[OFFSET_W-1:0] + offset_t'(lane);
      VD_SRC_IDX_PLUS_UIMM: return base + offset_t'(imm5) + offset_t'(lane);
      VD_SRC_IDX_PLUS_1:    return base + offset_t'(lane + 1);
      default:              return base + offset_t'(lane);
    endcase
  endfunction

  function automatic word_t red_expect();
    case (red_op)
      RED_AND, RED_MINU: return 32'hffff_ffff;
      RED_MIN:           return 32'h7fff_ffff;
      RED_MAX:           return 32'h8000_0000;
      default:           return 32'h0;
    endcase
  endfunction

  // expands the instruction on the inputs into its record list
  task automatic build_expected();
    rec_t r;
    int   fields;
    int   regs;
    int   ev;
    int   o;
    logic mem;
    logic win;
    exp_q.delete();
    mem    = is_load | is_store;
    ev     = (mem && full_reg) ? ELEMS_PER_REG * (int'(nf) + 1) : int'(vl);
    fields = (mem && !full_reg && nf != 0) ? int'(nf) + 1 : 1;
    regs   = regs_per_field();
    win    = (vstart < vl) && !is_store;
    for (int f = 0; f < fields; f++) begin
      o = int'(vstart);
      do begin
        r.vd   = reg_idx_t'(int'(vd) + f * regs);
        r.wo0  = vd_expect(offset_t'(o), 0);
        r.wo1  = vd_expect(offset_t'(o), 1);
        r.vo0  = vs2_expect(offset_t'(o), 0);
        r.vo1  = vs2_expect(offset_t'(o), 1);
        r.wen0 = win && (vm || mask_bits[0]);
        r.wen1 = win && (vm || mask_bits[1]) && (red_op == RED_NONE);
        r.red  = red_expect();
        r.vl   = vl_t'(ev);
        r.done = (f == fields - 1) && (o + LANES >= ev);
        exp_q.push_back(r);
        o += LANES;
      end while (o < ev);
    end
  endtask

  task automatic check_record();
    rec_t e;
    if (exp_q.size() == 0) begin
      n_errors++;
      $display("ERROR at %0t: a valid record appeared with none left to expect", $time);
    end else begin
      e = exp_q.pop_front();
      check_reg("de_vd", de_vd, e.vd);
      check_offset("de_woffset0", de_woffset0, e.wo0);
      check_offset("de_woffset1", de_woffset1, e.wo1);
      check_offset("de_vs2_offset0", de_vs2_offset0, e.vo0);
      check_offset("de_vs2_offset1", de_vs2_offset1, e.vo1);
      check_bit("de_wen0", de_wen0, e.wen0);
      check_bit("de_wen1", de_wen1, e.wen1);
      check_word("de_red_init", de_red_init, e.red);
      check_word("de_vl", de_vl, e.vl);
      check_bit("de_done", de_done, e.done);
    end
  endtask

  task automatic rand_fields();
    sew       <= sew_t'(2'($urandom_range(2)));
    lmul      <= lmul_tbl[3'($urandom_range(5))];
    eew       <= width_t'(2'($urandom_range(2)));
    vl        <= $urandom_range(32, 1);
    vstart    <= $urandom_range(7);
    is_load   <= 1'b0;
    is_store  <= 1'b0;
    full_reg  <= 1'b0;
    nf        <= '0;
    vd        <= 5'($urandom_range(31));
    vs2_src   <= vs2_src_t'(3'($urandom_range(7)));
    vd_src    <= vd_src_t'(3'($urandom_range(4)));
    xs1       <= $urandom();
    imm5      <= 5'($urandom_range(31));
    vm        <= 1'($urandom_range(1));
    mask_bits <= 2'($urandom_range(3));
    red_op    <= RED_NONE;
  endtask

  // pulses v_start for the fields just driven and checks every captured record
  task automatic run_instr(input int unsigned stall_pct);
    int   cycles;
    logic cap;
    logic st;
    logic seen_done;
    v_start <= 1'b1;
    stall   <= 1'b0;
    @(posedge CLK);
    build_expected();
    v_start   <= 1'b0;
    st        = ($urandom_range(99) < stall_pct);
    stall     <= st;
    seen_done = 1'b0;
    cycles    = 0;
    while (!seen_done && cycles < 2000) begin
      cap = ~st;
      @(posedge CLK);
      st    = ($urandom_range(99) < stall_pct);
      stall <= st;
      @(negedge CLK);
      check_bit("busy", busy, 1'b1);
      if (cap) begin
        // every unstalled cycle of the walk leaves one record
        check_bit("de_valid", de_valid, 1'b1);
        if (de_valid) begin
          seen_done = de_done;
          check_record();
        end
      end
      cycles++;
    end
    if (!seen_done) begin
      $display("ERROR: timed out after %0d cycles waiting for de_done", cycles);
      $display("*** TEST FAILED ***");
      $finish;
    end else begin
      @(posedge CLK);
      stall <= 1'b0;
      @(negedge CLK);
      check_bit("busy after done", busy, 1'b0);
      @(posedge CLK);
      @(negedge CLK);
      check_bit("de_valid after done", de_valid, 1'b0);
      if (exp_q.size() != 0) begin
        n_errors++;
        $display("ERROR: %0d expected records never appeared", exp_q.size());
      end
    end
  endtask

  task automatic run_flush();
    @(posedge CLK);
    rand_fields();
    vl      <= 32'd32;
    vstart  <= '0;
    v_start <= 1'b1;
    @(posedge CLK);
    v_start <= 1'b0;
    repeat (4) @(posedge CLK);
    @(negedge CLK);
    check_bit("busy before flush", busy, 1'b1);
    @(posedge CLK);
    flush <= 1'b1;
    @(posedge CLK);
    flush <= 1'b0;
    @(negedge CLK);
    check_bit("busy after flush", busy, 1'b0);
    check_bit("de_valid after flush", de_valid, 1'b0);
    repeat (2) @(posedge CLK);
    @(negedge CLK);
    check_bit("de_valid two cycles after flush", de_valid, 1'b0);
  endtask

  task automatic end_test(input string name);
    n_tests++;
    $display("test %0d %s finished with %0d errors", n_tests, name, n_errors - test_err0);
    test_err0 = n_errors;
  endtask

  initial begin
    void'($urandom(32'h77b));
    nRST    <= 1'b0;
    v_start <= 1'b0;
    stall   <= 1'b0;
    flush   <= 1'b0;
    rand_fields();
    repeat (3) @(posedge CLK);
    nRST <= 1'b1;

    for (int i = 0; i < 4; i++) begin
      @(posedge CLK);
      rand_fields();
      vs2_src <= VS2_SRC_NORMAL;
      vd_src  <= VD_SRC_NORMAL;
      vm      <= 1'b1;
      run_instr(0);
    end
    end_test("element walk");

    for (int i = 0; i < 8; i++) begin
      @(posedge CLK);
      rand_fields();
      vs2_src <= vs2_src_t'(3'(i));
      vd_src  <= vd_src_t'(3'(i % 5));
      run_instr(0);
    end
    end_test("offset sources");

    // vstart may land past vl here
    for (int i = 0; i < 10; i++) begin
      @(posedge CLK);
      rand_fields();
      vstart   <= $urandom_range(40);
      is_store <= 1'($urandom_range(1));
      run_instr(0);
    end
    end_test("masking and window");

    // segment loads first and whole-register accesses after
    for (int i = 0; i < 12; i++) begin
      @(posedge CLK);
      rand_fields();
      is_load  <= (i < 8) || (i % 2 == 0);
      is_store <= (i >= 8) && (i % 2 == 1);
      full_reg <= (i >= 8);
      nf       <= 3'($urandom_range(7, (i < 8) ? 1 : 0));
      run_instr(0);
    end
    end_test("segments and emul");

    for (int i = 0; i < 7; i++) begin
      @(posedge CLK);
      rand_fields();
      red_op <= red_op_t'(3'(i));
      vm     <= 1'b1;
      run_instr(0);
    end
    end_test("reduction identity");

    for (int i = 0; i < 12; i++) begin
      @(posedge CLK);
      rand_fields();
      is_load  <= (i % 3 == 1);
      full_reg <= (i % 6 == 4);
      nf       <= 3'($urandom_range(3));
      red_op   <= (i % 3 == 2) ? RED_MAX : RED_NONE;
      run_instr(40);
    end
    run_flush();
    @(posedge CLK);
    rand_fields();
    run_instr(40);
    end_test("stall and flush");

    $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* filelist.f */
source/vdecode_pkg.sv
source/element_counter.sv
source/emul_calc.sv
source/segment_sequencer.sv
source/offset_select.sv
source/decode_execute_reg.sv
source/vdecode_stage.sv
tb/tb_vdecode_sva.sv
tb/tb_vdecode.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the vector decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f filelist.f --top-module tb_vdecode \
    -o sim_tb_vdecode; then
  echo "verilator build failed"
  exit 1
fi

if ! sim_out="$(./obj_dir/sim_tb_vdecode)"; then
  echo "$sim_out"
  echo "simulation exited with an error status"
  exit 1
fi
echo "$sim_out"

if grep -qF "*** TEST PASSED ***" <<< "$sim_out"; then
  exit 0
fi
exit 1
